// File: list.f
+incdir+source
source/texcache_pkg.sv
source/tex_point_gen.sv
source/tex_quad_ram.sv
source/tex_cache.sv
source/tex_bilinear.sv
source/tex_unit_top.sv
verification/tex_unit_assertions.sv
verification/tex_unit_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the texel fetch testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module tex_unit_tb -f list.f -o tex_unit_sim > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tex_unit_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Finished with errors" sim.log; then
	exit 1
fi
exit 0

// File: verification/tex_unit_tb.sv
// ==================================================
// Testbench for the texel unit: memory model, test table, pixel checks.
// ==================================================
`timescale 1ns/1ns
`include "texcache_defs.svh"

module tex_unit_tb import texcache_pkg::*; ();

	localparam int          TIMEOUT = 2000; // Cycles per wait.
	localparam int unsigned BASE    = 32'h0001_0000;
	localparam int          HRES    = 64;

	typedef struct {
		string name;
		int    u_int;
		int    u_frac;
		int    v_int;
		int    v_frac;
		int    dadr;
		bit    flush;     // Flush the cache first.
		bit    stall;     // Random back-pressure, pixel not awaited.
		int    max_fills;
	} test_t;

	logic                  sys_clk;
	logic                  sys_rst;
	logic                  flush_i;
	logic                  busy_o;
	logic                  req_stb_i;
	tex_req_t              req_i;
	logic                  req_ack_o;
	logic                  pix_stb_o;
	tex_pixel_t            pix_o;
	logic                  pix_ack_i;
	logic                  wb_cyc_o;
	logic                  wb_stb_o;
	logic [`TEX_ADR_W-1:0] wb_adr_o;
	logic                  wb_ack_i;
	logic [63:0]           wb_dat_i;

	test_t       tests [$];
	int          pending [$]; // Test indices, request order.
	int          fill_start [64];
	int          fill_count;
	int          errors;
	int          tests_done;
	int          ack_delay;
	bit          cyc_q;
	bit          stall_en;
	bit          timed_out;
	int unsigned seed_ret;

	tex_unit_top dut_i (
		.sys_clk    (sys_clk),
		.sys_rst    (sys_rst),
		.tex_base_i (texel_adr_t'(BASE)),
		.tex_hres_i (`TEX_INT_W'(HRES)),
		.flush_i    (flush_i),
		.busy_o     (busy_o),
		.req_stb_i  (req_stb_i),
		.req_i      (req_i),
		.req_ack_o  (req_ack_o),
		.pix_stb_o  (pix_stb_o),
		.pix_o      (pix_o),
		.pix_ack_i  (pix_ack_i),
		.wb_cyc_o   (wb_cyc_o),
		.wb_stb_o   (wb_stb_o),
		.wb_adr_o   (wb_adr_o),
		.wb_ack_i   (wb_ack_i),
		.wb_dat_i   (wb_dat_i)
	);

	initial begin
		sys_clk = 1'b0;
		forever #50 sys_clk = ~sys_clk;
	end

	// ==================================================
	// Reference model
	// ==================================================
	function automatic logic [15:0] texel_at(input int unsigned adr);
		logic [31:0] prod;
		prod = (adr >> 1) * 32'd40503; // Word address times the pattern constant.
		return prod[15:0] ^ 16'h5a5a;
	endfunction

	function automatic int mix_chan(input int a, input int b, input int c, input int d,
		input int x, input int y);
		int top;
		int bot;
		top = a * (64 - x) + b * x;
		bot = c * (64 - x) + d * x;
		return (top * (64 - y) + bot * y) >> 12;
	endfunction

	function automatic logic [15:0] expect_color(input test_t t);
		int unsigned adr_a;
		int unsigned adr_c;
		logic [15:0] ta, tb, tc, td;
		int          r, g, b;
		adr_a = BASE + 2 * (t.v_int * HRES + t.u_int);
		adr_c = adr_a + 2 * HRES; // Next row.
		ta = texel_at(adr_a);
		tb = texel_at(adr_a + 2);
		tc = texel_at(adr_c);
		td = texel_at(adr_c + 2);
		r = mix_chan(ta[15:11], tb[15:11], tc[15:11], td[15:11], t.u_frac, t.v_frac);
		g = mix_chan(ta[10:5], tb[10:5], tc[10:5], td[10:5], t.u_frac, t.v_frac);
		b = mix_chan(ta[4:0], tb[4:0], tc[4:0], td[4:0], t.u_frac, t.v_frac);
		return {r[4:0], g[5:0], b[4:0]};
	endfunction

	task automatic check(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			errors++;
			$display("FAIL %s: expected %h, got %h", what, expected, actual);
		end
	endtask

	task automatic add_test(input string name, input int ui, input int uf, input int vi,
		input int vf, input int dadr, input bit flush, input bit stall, input int max_fills);
		test_t t;
		t = '{name, ui, uf, vi, vf, dadr, flush, stall, max_fills};
		tests.push_back(t);
	endtask

	// ==================================================
	// Memory model and pixel sink
	// ==================================================
	always @(negedge sys_clk) begin : negedge_models
		int          idx;
		int          fills;
		int          errs_before;
		int unsigned adr;
		if (wb_cyc_o && !cyc_q)
			fill_count++;
		cyc_q = wb_cyc_o;
		if (wb_ack_i) begin
			wb_ack_i  = 1'b0;
			ack_delay = $urandom % 4;
		end else if (wb_stb_o) begin
			if (ack_delay == 0) begin
				adr      = wb_adr_o;
				wb_dat_i = {texel_at(adr), texel_at(adr + 2), texel_at(adr + 4),
					texel_at(adr + 6)}; // Lowest address in the top bits.
				wb_ack_i = 1'b1;
			end else
				ack_delay--;
		end
		pix_ack_i = stall_en ? ($urandom % 4 != 0) : 1'b1;
		if (!sys_rst && pix_stb_o && pix_ack_i) begin
			if (pending.size() == 0) begin
				errors++;
				$display("ERROR: pixel for %h arrived with no request outstanding",
					pix_o.dadr);
			end else begin
				idx         = pending.pop_front();
				errs_before = errors;
				fills       = fill_count - fill_start[idx];
				check({tests[idx].name, " dadr"}, tests[idx].dadr, pix_o.dadr);
				check({tests[idx].name, " color"}, expect_color(tests[idx]), pix_o.color);
				check({tests[idx].name, " fills in bound"}, 1, fills <= tests[idx].max_fills);
				if (tests[idx].flush)
					check({tests[idx].name, " refilled"}, 1, fills > 0);
				tests_done++;
				$display("%s %s", (errors == errs_before) ? "ok  " : "bad ", tests[idx].name);
			end
		end
	end

	// ==================================================
	// Waits, each with its own timeout
	// ==================================================
	task automatic wait_not_busy();
		int t;
		t = 0;
		@(posedge sys_clk);
		while (busy_o) begin
			t++;
			if (t >= TIMEOUT) begin
				$display("ERROR: busy_o stayed high for %0d cycles", TIMEOUT);
				timed_out = 1'b1;
				return;
			end
			@(posedge sys_clk);
		end
	endtask

	task automatic wait_drained();
		int t;
		t = 0;
		@(posedge sys_clk);
		while (pending.size() != 0) begin
			t++;
			if (t >= TIMEOUT) begin
				$display("ERROR: %0d pixels never came out", pending.size());
				timed_out = 1'b1;
				return;
			end
			@(posedge sys_clk);
		end
	endtask

	task automatic send_req(input int idx);
		int t;
		fill_start[idx] = fill_count;
		@(negedge sys_clk);
		req_i.dadr   = tests[idx].dadr;
		req_i.u_int  = tests[idx].u_int;
		req_i.u_frac = tests[idx].u_frac;
		req_i.v_int  = tests[idx].v_int;
		req_i.v_frac = tests[idx].v_frac;
		req_stb_i    = 1'b1;
		t = 0;
		@(posedge sys_clk);
		while (!req_ack_o) begin
			t++;
			if (t >= TIMEOUT) begin
				$display("ERROR: request %s was never accepted", tests[idx].name);
				timed_out = 1'b1;
				return;
			end
			@(posedge sys_clk);
		end
		pending.push_back(idx);
		@(negedge sys_clk);
		req_stb_i = 1'b0;
	endtask

	task automatic flush_cache();
		wait_not_busy();
		if (timed_out)
			return;
		@(negedge sys_clk);
		flush_i = 1'b1;
		@(negedge sys_clk);
		flush_i = 1'b0;
		wait_not_busy();
	endtask

	// ==================================================
	// Test table and main sequence
	// ==================================================
	initial begin
		seed_ret   = $urandom(32'h054c6b78);
		sys_rst    = 1'b1;
		flush_i    = 1'b0;
		req_stb_i  = 1'b0;
		req_i      = '0;
		pix_ack_i  = 1'b0;
		wb_ack_i   = 1'b0;
		wb_dat_i   = '0;
		fill_count = 0;
		errors     = 0;
		tests_done = 0;
		ack_delay  = 0;
		cyc_q      = 1'b0;
		stall_en   = 1'b0;
		timed_out  = 1'b0;
		//       name             u  uf  v  vf  dadr   flush stall fills
		add_test("int_a",          3, 0,  2, 0,  'h100, 0, 0, 1);
		add_test("int_b",         17, 0,  5, 0,  'h101, 0, 0, 1);
		add_test("frac_a",         6, 21, 9, 40, 'h102, 0, 0, 4);
		add_test("frac_edge",     15, 63, 3, 1,  'h103, 0, 0, 4);
		add_test("repeat_int_b",  17, 0,  5, 0,  'h104, 0, 0, 0);
		add_test("repeat_frac_a",  6, 21, 9, 40, 'h105, 0, 0, 0);
		add_test("flush_frac_a",   6, 21, 9, 40, 'h106, 1, 0, 4);
		add_test("evict_lo",       8, 0,  4, 0,  'h107, 0, 0, 1);
		add_test("evict_hi",       8, 0, 12, 0,  'h108, 0, 0, 1); // Same index, next tag.
		add_test("evict_lo_again", 8, 0,  4, 0,  'h109, 0, 0, 1);
		add_test("stall_0",        6, 21, 9, 40, 'h10a, 0, 1, 0);
		add_test("stall_1",        8, 0,  4, 0,  'h10b, 0, 1, 0);
		add_test("stall_2",        5, 33, 9, 12, 'h10c, 0, 1, 0);
		add_test("stall_3",        6, 0,  9, 50, 'h10d, 0, 1, 0);
		add_test("stall_4",        7, 0, 10, 0,  'h10e, 0, 1, 0);
		add_test("stall_5",        6, 63, 9, 63, 'h10f, 0, 1, 0);
		repeat (5) @(negedge sys_clk);
		sys_rst = 1'b0;
		wait_not_busy(); // Tags clear out of reset.
		for (int i = 0; i < tests.size(); i++) begin
			if (timed_out)
				break;
			if (!tests[i].stall) begin
				wait_drained();
				stall_en = 1'b0;
				if (tests[i].flush && !timed_out)
					flush_cache();
				if (!timed_out)
					send_req(i);
				if (!timed_out)
					wait_drained();
			end else begin
				stall_en = 1'b1;
				send_req(i);
			end
		end
		if (!timed_out)
			wait_drained();
		$display("%0d of %0d tests finished, %0d errors", tests_done, tests.size(), errors);
		if (errors == 0 && !timed_out)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

// File: verification/tex_unit_assertions.sv
// ==================================================
// Handshake checks on the texel unit, bound to its top.
// ==================================================
`timescale 1ns/1ns
`include "texcache_defs.svh"

module tex_unit_assertions import texcache_pkg::*; (
	input logic                  sys_clk,
	input logic                  sys_rst,
	input logic                  wb_cyc_o,
	input logic                  wb_stb_o,
	input logic [`TEX_ADR_W-1:0] wb_adr_o,
	input logic                  wb_ack_i,
	input logic                  pix_stb_o,
	input tex_pixel_t            pix_o,
	input logic                  pix_ack_i,
	input logic [2:0]            cache_state_i
);

	localparam logic [2:0] FLUSH_STATE = 3'd6; // Flush state of the cache FSM.

	a_stb_in_cyc: assert property (@(posedge sys_clk) disable iff (sys_rst)
		wb_stb_o |-> wb_cyc_o)
		else $error("wb_stb_o high without wb_cyc_o");

	a_wb_hold: assert property (@(posedge sys_clk) disable iff (sys_rst)
		wb_stb_o && !wb_ack_i |=> wb_stb_o && $stable(wb_adr_o))
		else $error("Wishbone strobe or address dropped before ack");

	a_pix_hold: assert property (@(posedge sys_clk) disable iff (sys_rst)
		pix_stb_o && !pix_ack_i |=> pix_stb_o && $stable(pix_o))
		else $error("pixel strobe or payload changed before ack");

	a_flush_quiet: assert property (@(posedge sys_clk) disable iff (sys_rst)
		(cache_state_i == FLUSH_STATE) |-> !wb_cyc_o)
		else $error("Wishbone cycle open during tag flush");

endmodule

bind tex_unit_top tex_unit_assertions assertions_i (
	.sys_clk       (sys_clk),
	.sys_rst       (sys_rst),
	.wb_cyc_o      (wb_cyc_o),
	.wb_stb_o      (wb_stb_o),
	.wb_adr_o      (wb_adr_o),
	.wb_ack_i      (wb_ack_i),
	.pix_stb_o     (pix_stb_o),
	.pix_o         (pix_o),
	.pix_ack_i     (pix_ack_i),
	.cache_state_i (cache.state)
);

// File: source/tex_unit_top.sv
// ==================================================
// Texel fetch path: point generator, cache, filter.
// Requests in, tagged pixels out, Wishbone reads to memory.
// ==================================================
`timescale 1ns/1ns
`include "texcache_defs.svh"

module tex_unit_top import texcache_pkg::*; (
	input  logic                  sys_clk,
	input  logic                  sys_rst,
	input  texel_adr_t            tex_base_i,
	input  logic [`TEX_INT_W-1:0] tex_hres_i,
	input  logic                  flush_i,
	output logic                  busy_o,
	input  logic                  req_stb_i,
	input  tex_req_t              req_i,
	output logic                  req_ack_o,
	output logic                  pix_stb_o,
	output tex_pixel_t            pix_o,
	input  logic                  pix_ack_i,
	output logic                  wb_cyc_o,
	output logic                  wb_stb_o,
	output logic [`TEX_ADR_W-1:0] wb_adr_o,
	input  logic                  wb_ack_i,
	input  logic [63:0]           wb_dat_i
);

	logic        quad_stb, quad_ack;
	tex_quad_t   quad;
	logic        colors_stb, colors_ack;
	tex_colors_t colors;

	tex_point_gen point_gen (
		.sys_clk    (sys_clk),
		.sys_rst    (sys_rst),
		.tex_base_i (tex_base_i),
		.tex_hres_i (tex_hres_i),
		.req_stb_i  (req_stb_i),
		.req_i      (req_i),
		.req_ack_o  (req_ack_o),
		.quad_stb_o (quad_stb),
		.quad_o     (quad),
		.quad_ack_i (quad_ack)
	);

	tex_cache cache (
		.sys_clk      (sys_clk),
		.sys_rst      (sys_rst),
		.flush_i      (flush_i),
		.busy_o       (busy_o), // Cache state stands for the unit.
		.quad_stb_i   (quad_stb),
		.quad_i       (quad),
		.quad_ack_o   (quad_ack),
		.colors_stb_o (colors_stb),
		.colors_o     (colors),
		.colors_ack_i (colors_ack),
		.wb_cyc_o     (wb_cyc_o),
		.wb_stb_o     (wb_stb_o),
		.wb_adr_o     (wb_adr_o),
		.wb_ack_i     (wb_ack_i),
		.wb_dat_i     (wb_dat_i)
	);

	tex_bilinear filter (
		.sys_clk      (sys_clk),
		.sys_rst      (sys_rst),
		.colors_stb_i (colors_stb),
		.colors_i     (colors),
		.colors_ack_o (colors_ack),
		.pix_stb_o    (pix_stb_o),
		.pix_o        (pix_o),
		.pix_ack_i    (pix_ack_i)
	);

endmodule

// File: source/tex_bilinear.sv
// ==================================================
// Bilinear blend of four RGB565 texels.
// Horizontal pass, then vertical pass, one register each.
// ==================================================
`timescale 1ns/1ns
`include "texcache_defs.svh"

module tex_bilinear import texcache_pkg::*; (
	input  logic        sys_clk,
	input  logic        sys_rst,
	input  logic        colors_stb_i,
	input  tex_colors_t colors_i,
	output logic        colors_ack_o,
	output logic        pix_stb_o,
	output tex_pixel_t  pix_o,
	input  logic        pix_ack_i
);

	localparam int SHIFT = 2 * `TEX_FRAC_W;

	// p*(1-f) + q*f, with 1 scaled to 2^FRAC_W.
	function automatic logic [17:0] lerp(input logic [11:0] p, input logic [11:0] q,
		input logic [`TEX_FRAC_W-1:0] f);
		logic [`TEX_FRAC_W:0] wp;
		wp = (`TEX_FRAC_W+1)'(1 << `TEX_FRAC_W) - (`TEX_FRAC_W+1)'(f);
		return 18'(p) * 18'(wp) + 18'(q) * 18'(f);
	endfunction

	function automatic logic [11:0] chan(input texel_t t, input int i);
		case (i)
			0:       return 12'(t.r);
			1:       return 12'(t.g);
			default: return 12'(t.b);
		endcase
	endfunction

	logic                   advance;
	logic                   s1_valid;
	logic [11:0]            top_n [3];
	logic [11:0]            bot_n [3];
	logic [11:0]            top_q [3];
	logic [11:0]            bot_q [3];
	logic [`TEX_FRAC_W-1:0] y_q;
	logic [`TEX_DADR_W-1:0] dadr_q;
	logic [17:0]            mix [3];

	always_comb begin
		for (int i = 0; i < 3; i++) begin
			top_n[i] = 12'(lerp(chan(colors_i.a, i), chan(colors_i.b, i), colors_i.x_frac));
			bot_n[i] = 12'(lerp(chan(colors_i.c, i), chan(colors_i.d, i), colors_i.x_frac));
			mix[i]   = lerp(top_q[i], bot_q[i], y_q);
		end
	end

	assign advance      = ~pix_stb_o | pix_ack_i; // Both stages move together.
	assign colors_ack_o = advance;

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			s1_valid  <= 1'b0;
			pix_stb_o <= 1'b0;
		end else if (advance) begin
			s1_valid  <= colors_stb_i;
			pix_stb_o <= s1_valid;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (advance) begin
			top_q  <= top_n;
			bot_q  <= bot_n;
			y_q    <= colors_i.y_frac;
			dadr_q <= colors_i.dadr;
			pix_o.dadr    <= dadr_q;
			pix_o.color.r <= mix[0][SHIFT +: 5]; // Truncated.
			pix_o.color.g <= mix[1][SHIFT +: 6];
			pix_o.color.b <= mix[2][SHIFT +: 5];
		end
	end

endmodule

// File: source/tex_cache.sv
// ==================================================
// Direct-mapped texel cache, 32-byte lines.
// Misses hold the request and fill over Wishbone classic.
// ==================================================
`timescale 1ns/1ns
`include "texcache_defs.svh"

module tex_cache import texcache_pkg::*; (
	input  logic                  sys_clk,
	input  logic                  sys_rst,
	input  logic                  flush_i,
	output logic                  busy_o,
	input  logic                  quad_stb_i,
	input  tex_quad_t             quad_i,
	output logic                  quad_ack_o,
	output logic                  colors_stb_o,
	output tex_colors_t           colors_o,
	input  logic                  colors_ack_i,
	output logic                  wb_cyc_o,
	output logic                  wb_stb_o,
	output logic [`TEX_ADR_W-1:0] wb_adr_o,
	input  logic                  wb_ack_i,
	input  logic [63:0]           wb_dat_i
);

	localparam int IDX_W  = `TEX_CACHE_DEPTH - `TEX_LINE_BITS;
	localparam int WADR_W = `TEX_CACHE_DEPTH - 2; // 32-bit words.

	typedef enum logic [2:0] {
		S_IDLE, S_FETCH, S_GAP, S_SETTLE1, S_SETTLE2, S_SETTLE3, S_FLUSH
	} state_t;

	// ==================================================
	// Lookup
	// ==================================================
	tex_quad_t         quad_r;
	logic              req_valid;
	logic              lookup_ok; // Tag outputs are meaningful.
	texel_adr_t        cur_adr [4];
	texel_adr_t        held_adr [4];
	logic [IDX_W-1:0]  tag_rd_adr [4];
	logic [WADR_W-1:0] data_rd_adr [4];
	tag_entry_t        tag_rd [4];
	line_word_t        word_rd [4];
	texel_t            texel [4];
	logic [3:0]        needed;
	logic [3:0]        hit;
	logic              all_hit;

	state_t            state, state_n;
	logic [1:0]        beat;
	logic [IDX_W-1:0]  flush_cnt;
	logic [31:0]       beat_lo;
	texel_adr_t        fetch_adr;
	logic              fetch_needed;
	logic              tag_we;
	logic [IDX_W-1:0]  tag_wr_adr;
	tag_entry_t        tag_wr_dat;
	logic              data_we;
	logic [WADR_W-1:0] data_wr_adr;
	line_word_t        data_wr_dat;

	always_comb begin
		cur_adr  = '{quad_i.a, quad_i.b, quad_i.c, quad_i.d};
		held_adr = '{quad_r.a, quad_r.b, quad_r.c, quad_r.d};
		for (int i = 0; i < 4; i++) begin
			// Keep reading the held request until it leaves.
			tag_rd_adr[i]  = quad_ack_o ? cur_adr[i][`TEX_CACHE_DEPTH-1:`TEX_LINE_BITS]
				: held_adr[i][`TEX_CACHE_DEPTH-1:`TEX_LINE_BITS];
			data_rd_adr[i] = quad_ack_o ? cur_adr[i][`TEX_CACHE_DEPTH-1:2]
				: held_adr[i][`TEX_CACHE_DEPTH-1:2];
		end
	end

	tex_quad_ram #(.word_t(tag_entry_t), .depth(IDX_W)) tag_ram (
		.sys_clk  (sys_clk),
		.rd_adr_i (tag_rd_adr),
		.rd_dat_o (tag_rd),
		.wr_en_i  (tag_we),
		.wr_adr_i (tag_wr_adr),
		.wr_dat_i (tag_wr_dat)
	);

	tex_quad_ram #(.word_t(line_word_t), .depth(WADR_W)) data_ram (
		.sys_clk  (sys_clk),
		.rd_adr_i (data_rd_adr),
		.rd_dat_o (word_rd),
		.wr_en_i  (data_we),
		.wr_adr_i (data_wr_adr),
		.wr_dat_i (data_wr_dat)
	);

	// Zero weights make B, C, D don't-cares.
	assign needed = {(quad_r.x_frac != '0) | (quad_r.y_frac != '0),
		quad_r.y_frac != '0, quad_r.x_frac != '0, 1'b1};

	always_comb begin
		for (int i = 0; i < 4; i++) begin
			hit[i] = ~needed[i] | (tag_rd[i].valid
				& (tag_rd[i].tag == held_adr[i][`TEX_ADR_W-1:`TEX_CACHE_DEPTH]));
			texel[i] = held_adr[i][1] ? word_rd[i].lo : word_rd[i].hi;
		end
	end

	assign all_hit      = lookup_ok & (&hit);
	assign colors_stb_o = req_valid & all_hit;
	assign quad_ack_o   = ~req_valid | (colors_stb_o & colors_ack_i);

	always_comb begin
		colors_o.a      = texel[0];
		colors_o.b      = texel[1];
		colors_o.c      = texel[2];
		colors_o.d      = texel[3];
		colors_o.x_frac = quad_r.x_frac;
		colors_o.y_frac = quad_r.y_frac;
		colors_o.dadr   = quad_r.dadr;
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			req_valid    <= 1'b0;
			lookup_ok    <= 1'b0;
			fetch_needed <= 1'b0;
		end else begin
			if (quad_ack_o)
				req_valid <= quad_stb_i;
			lookup_ok    <= (state != S_FLUSH); // Skip the cycle after a tag clear.
			fetch_needed <= req_valid & lookup_ok & ~all_hit;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (quad_ack_o & quad_stb_i)
			quad_r <= quad_i;
		// First missing texel, frozen during a fill.
		if (req_valid & lookup_ok & ~all_hit & ~wb_cyc_o) begin
			if (!hit[0])
				fetch_adr <= held_adr[0];
			else if (!hit[1])
				fetch_adr <= held_adr[1];
			else if (!hit[2])
				fetch_adr <= held_adr[2];
			else
				fetch_adr <= held_adr[3];
		end
	end

	// ==================================================
	// Fill and flush controller
	// ==================================================
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			state     <= S_FLUSH; // Clear tags out of reset.
			beat      <= 2'd0;
			flush_cnt <= '0;
		end else begin
			state <= state_n;
			if (state == S_GAP)
				beat <= beat + 2'd1;
			flush_cnt <= (state == S_FLUSH) ? flush_cnt + 1'b1 : '0;
		end
	end

	always_ff @(posedge sys_clk) begin
		if ((state == S_FETCH) & wb_ack_i)
			beat_lo <= wb_dat_i[31:0]; // Written in the gap cycle.
	end

	always_comb begin
		state_n = state;
		case (state)
			S_IDLE: begin
				if (flush_i)
					state_n = S_FLUSH;
				else if (fetch_needed)
					state_n = S_FETCH;
			end
			S_FETCH:   if (wb_ack_i) state_n = S_GAP;
			S_GAP:     state_n = (beat == 2'd3) ? S_SETTLE1 : S_FETCH;
			S_SETTLE1: state_n = S_SETTLE2;
			S_SETTLE2: state_n = S_SETTLE3;
			S_SETTLE3: state_n = S_IDLE;
			S_FLUSH:   if (&flush_cnt) state_n = S_IDLE;
			default:   state_n = S_IDLE;
		endcase
	end

	// Tag goes in with the last data word.
	assign tag_we     = ((state == S_GAP) & (beat == 2'd3)) | (state == S_FLUSH);
	assign tag_wr_adr = (state == S_FLUSH) ? flush_cnt
		: fetch_adr[`TEX_CACHE_DEPTH-1:`TEX_LINE_BITS];
	assign tag_wr_dat = '{valid: state != S_FLUSH,
		tag: fetch_adr[`TEX_ADR_W-1:`TEX_CACHE_DEPTH]};

	assign data_we     = ((state == S_FETCH) & wb_ack_i) | (state == S_GAP);
	assign data_wr_adr = {fetch_adr[`TEX_CACHE_DEPTH-1:`TEX_LINE_BITS], beat, state == S_GAP};
	assign data_wr_dat = line_word_t'((state == S_GAP) ? beat_lo : wb_dat_i[63:32]);

	assign wb_cyc_o = (state == S_FETCH) | (state == S_GAP);
	assign wb_stb_o = (state == S_FETCH);
	assign wb_adr_o = {fetch_adr[`TEX_ADR_W-1:`TEX_LINE_BITS], beat, 3'b000};

	assign busy_o = (state != S_IDLE) | req_valid;

endmodule

// File: source/tex_quad_ram.sv
// ==================================================
// Four synchronous read ports over one write port.
// Word type is a parameter, depth is log2 of the word count.
// ==================================================
`timescale 1ns/1ns

module tex_quad_ram #(
	parameter type word_t = logic [31:0],
	parameter int  depth  = 8
) (
	input  logic             sys_clk,
	input  logic [depth-1:0] rd_adr_i [4],
	output word_t            rd_dat_o [4],
	input  logic             wr_en_i,
	input  logic [depth-1:0] wr_adr_i,
	input  word_t            wr_dat_i
);

	// One copy of the array per read port, all written alike.
	for (genvar p = 0; p < 4; p++) begin : g_port
		word_t mem [2**depth];
		word_t rd_q;

		always_ff @(posedge sys_clk) begin
			if (wr_en_i)
				mem[wr_adr_i] <= wr_dat_i;
			rd_q <= mem[rd_adr_i[p]]; // Old word on a same-cycle write.
		end

		assign rd_dat_o[p] = rd_q;
	end

endmodule

// File: source/tex_point_gen.sv
// ==================================================
// Turns a coordinate request into four texel addresses.
// One register slot, strobe/ack on both sides.
// ==================================================
`timescale 1ns/1ns
`include "texcache_defs.svh"

module tex_point_gen import texcache_pkg::*; (
	input  logic                  sys_clk,
	input  logic                  sys_rst,
	input  texel_adr_t            tex_base_i,
	input  logic [`TEX_INT_W-1:0] tex_hres_i,
	input  logic                  req_stb_i,
	input  tex_req_t              req_i,
	output logic                  req_ack_o,
	output logic                  quad_stb_o,
	output tex_quad_t             quad_o,
	input  logic                  quad_ack_i
);

	logic [2*`TEX_INT_W:0] texel_idx; // Linear texel index of A.
	logic [`TEX_INT_W:0]   pitch;     // Row length in bytes.
	texel_adr_t            adr_a;
	texel_adr_t            adr_c;

	always_comb begin
		texel_idx = req_i.v_int * tex_hres_i + req_i.u_int;
		pitch = {tex_hres_i, 1'b0};
		adr_a = tex_base_i + texel_adr_t'({texel_idx, 1'b0});
		adr_c = adr_a + texel_adr_t'(pitch); // One row down.
	end

	// Slot is free, or drains this cycle.
	assign req_ack_o = ~quad_stb_o | quad_ack_i;

	always_ff @(posedge sys_clk) begin
		if (sys_rst)
			quad_stb_o <= 1'b0;
		else if (req_ack_o)
			quad_stb_o <= req_stb_i;
	end

	always_ff @(posedge sys_clk) begin
		if (req_ack_o & req_stb_i) begin
			quad_o.a      <= adr_a;
			quad_o.b      <= adr_a + texel_adr_t'(2); // Right neighbour.
			quad_o.c      <= adr_c;
			quad_o.d      <= adr_c + texel_adr_t'(2);
			quad_o.x_frac <= req_i.u_frac;
			quad_o.y_frac <= req_i.v_frac;
			quad_o.dadr   <= req_i.dadr;
		end
	end

endmodule

// File: source/texcache_pkg.sv
// ==================================================
// Payload structs passed between the fetch stages.
// Import into any module that carries them.
// ==================================================
`include "texcache_defs.svh"

package texcache_pkg;

	typedef logic [`TEX_ADR_W-1:0] texel_adr_t; // Byte address.

	typedef struct packed {
		logic [`TEX_DADR_W-1:0] dadr;
		logic [`TEX_INT_W-1:0]  u_int;
		logic [`TEX_FRAC_W-1:0] u_frac;
		logic [`TEX_INT_W-1:0]  v_int;
		logic [`TEX_FRAC_W-1:0] v_frac;
	} tex_req_t;

	typedef struct packed {
		texel_adr_t a, b, c, d; // Top left, top right, bottom left, bottom right.
		logic [`TEX_FRAC_W-1:0] x_frac;
		logic [`TEX_FRAC_W-1:0] y_frac;
		logic [`TEX_DADR_W-1:0] dadr;
	} tex_quad_t;

	// RGB565, red in the top bits.
	typedef struct packed {
		logic [4:0] r;
		logic [5:0] g;
		logic [4:0] b;
	} texel_t;

	typedef struct packed {
		texel_t a, b, c, d;
		logic [`TEX_FRAC_W-1:0] x_frac;
		logic [`TEX_FRAC_W-1:0] y_frac;
		logic [`TEX_DADR_W-1:0] dadr;
	} tex_colors_t;

	typedef struct packed {
		logic valid;
		logic [`TEX_ADR_W-`TEX_CACHE_DEPTH-1:0] tag;
	} tag_entry_t;

	// Lower address sits in the upper half.
	typedef struct packed {
		texel_t hi;
		texel_t lo;
	} line_word_t;

	typedef struct packed {
		logic [`TEX_DADR_W-1:0] dadr;
		texel_t color;
	} tex_pixel_t;

endpackage

// File: source/texcache_defs.svh
// ==================================================
// Width macros for the texel fetch path.
// Include wherever an address or fraction width is needed.
// ==================================================
`ifndef TEXCACHE_DEFS_SVH
`define TEXCACHE_DEFS_SVH

// Byte address into texture memory.
`define TEX_ADR_W 24

// Log2 of cache capacity in bytes.
`define TEX_CACHE_DEPTH 10

// Log2 of line size. 32 bytes, four 64-bit beats.
`define TEX_LINE_BITS 5

// Fixed-point coordinate split.
`define TEX_FRAC_W 6
`define TEX_INT_W 10

// Destination pixel address.
`define TEX_DADR_W 16

`endif
